// File: hw/board_defines.svh
`ifndef BOARD_DEFINES_SVH
`define BOARD_DEFINES_SVH

// ---------------------------------------------------------------------------
// Board clock and slow clock

`define CLK_MHZ        27
`define SLOW_CLK_HALF  16     // Short half period for simulation

// ---------------------------------------------------------------------------
// 800x480 LCD timing, in pixel clocks and lines

`define H_ACTIVE       800
`define H_FRONT        40
`define H_SYNC         48
`define H_BACK         40

`define V_ACTIVE       480
`define V_FRONT        13
`define V_SYNC         3
`define V_BACK         32

// ---------------------------------------------------------------------------
// Audio

`define BCLK_HALF      4      // clk cycles per half bclk period
`define TONE_HALF      3000   // clk cycles per half tone period
`define TONE_AMPL      16'h2000

`endif

// File: hw/board_io_pkg.sv
`default_nettype none

package board_io_pkg;

    // Board buttons and switches, already inverted to active high
    typedef logic [4:0] key_t;
    typedef logic [4:0] sw_t;

    typedef logic [5:0] led_t;  // Active high inside the design

    // Two's complement PCM sample
    typedef logic signed [15:0] sample_t;

endpackage

`default_nettype wire

// File: hw/display_pkg.sv
`default_nettype none

package display_pkg;

    // Pixel coordinates inside the 800x480 active area
    typedef logic [9:0] x_t;
    typedef logic [8:0] y_t;

    // RGB565 channels
    typedef logic [4:0] red_t;
    typedef logic [5:0] green_t;
    typedef logic [4:0] blue_t;

endpackage

`default_nettype wire

// File: hw/slow_clk_gen.sv
`timescale 1ns/100ps
`default_nettype none

`include "board_defines.svh"

module slow_clk_gen
(
    input  logic clk,
    input  logic rst_n,
    output logic slow_clk
);

    localparam int cnt_w = (`SLOW_CLK_HALF > 1) ? $clog2(`SLOW_CLK_HALF) : 1;
    localparam logic [cnt_w - 1:0] cnt_last = cnt_w'(`SLOW_CLK_HALF - 1);

    logic [cnt_w - 1:0] cnt;

    // Toggle once per half period
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            cnt      <= '0;
            slow_clk <= 1'b0;
        end
        else if (cnt == cnt_last)
        begin
            cnt      <= '0;
            slow_clk <= ~slow_clk;
        end
        else
        begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hw/lcd_timing.sv
`timescale 1ns/100ps
`default_nettype none

`include "board_defines.svh"

module lcd_timing
(
    input  logic              clk,
    input  logic              rst_n,
    output logic              lcd_de,
    output logic              lcd_hs,
    output logic              lcd_vs,
    output display_pkg::x_t   x,
    output display_pkg::y_t   y
);

    import display_pkg::*;

    localparam logic [9:0] h_total    = 10'(`H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK);
    localparam logic [9:0] v_total    = 10'(`V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK);
    localparam logic [9:0] h_active   = 10'(`H_ACTIVE);
    localparam logic [9:0] v_active   = 10'(`V_ACTIVE);
    localparam logic [9:0] hs_start   = 10'(`H_ACTIVE + `H_FRONT);
    localparam logic [9:0] hs_end     = 10'(`H_ACTIVE + `H_FRONT + `H_SYNC);
    localparam logic [9:0] vs_start   = 10'(`V_ACTIVE + `V_FRONT);
    localparam logic [9:0] vs_end     = 10'(`V_ACTIVE + `V_FRONT + `V_SYNC);

    logic [9:0] h_cnt;
    logic [9:0] v_cnt;
    logic       h_last;
    logic       v_last;
    logic       active;

    assign h_last = h_cnt == h_total - 10'd1;
    assign v_last = v_cnt == v_total - 10'd1;
    assign active = (h_cnt < h_active) && (v_cnt < v_active);

    // ---------------------------------------------------------------------------
    // Position counters, one line per h_total clocks

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            h_cnt <= '0;
            v_cnt <= '0;
        end
        else
        begin
            h_cnt <= h_last ? '0 : h_cnt + 10'd1;

            if (h_last)
                v_cnt <= v_last ? '0 : v_cnt + 10'd1;
        end
    end

    // ---------------------------------------------------------------------------
    // Registered panel outputs, one clock behind the counters

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            lcd_de <= 1'b0;
            lcd_hs <= 1'b1;             // Syncs idle high
            lcd_vs <= 1'b1;
            x      <= '0;
            y      <= '0;
        end
        else
        begin
            lcd_de <= active;
            lcd_hs <= !((h_cnt >= hs_start) && (h_cnt < hs_end));
            lcd_vs <= !((v_cnt >= vs_start) && (v_cnt < vs_end));
            x      <= active ? x_t'(h_cnt) : '0;
            y      <= active ? y_t'(v_cnt) : '0;
        end
    end

    a_coord_in_range : assert property (@(posedge clk) disable iff (!rst_n)
        lcd_de |-> (x < x_t'(`H_ACTIVE)) && (y < y_t'(`V_ACTIVE)));

endmodule

`default_nettype wire

// File: hw/i2s_audio_out.sv
`timescale 1ns/100ps
`default_nettype none

`include "board_defines.svh"

module i2s_audio_out
#(
    parameter bit align_right         = 1'b0,
    parameter bit offset_by_one_cycle = 1'b0
)
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  board_io_pkg::sample_t data_in,
    output logic                  bclk,
    output logic                  lrclk,
    output logic                  sdata
);

    import board_io_pkg::*;

    localparam int div_w = (`BCLK_HALF > 1) ? $clog2(`BCLK_HALF) : 1;
    localparam logic [div_w - 1:0] div_last = div_w'(`BCLK_HALF - 1);

    logic [div_w - 1:0] div_cnt;
    logic               div_end;
    logic               bclk_fall;
    logic [5:0]         bit_cnt;        // Position in the 64 bclk frame
    logic [5:0]         bit_next;
    logic               slot_start;
    sample_t            sample_q;
    sample_t            slot_sample;
    logic [31:0]        slot_word;
    logic [31:0]        shreg;

    assign div_end    = div_cnt == div_last;
    assign bclk_fall  = div_end & bclk;
    assign bit_next   = bit_cnt + 6'd1;
    assign slot_start = bit_next[4:0] == 5'd0;

    // Left slot takes the fresh sample, right slot repeats it
    assign slot_sample = bit_next[5] ? sample_q : data_in;

    // Placement of the 16 bits inside the 32 bit slot
    always_comb
    begin
        if (align_right)
            slot_word = {16'b0, slot_sample};           // PT8211 style
        else if (offset_by_one_cycle)
            slot_word = {1'b0, slot_sample, 15'b0};     // Philips I2S
        else
            slot_word = {slot_sample, 16'b0};
    end

    // ---------------------------------------------------------------------------
    // Bit clock

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            div_cnt <= '0;
            bclk    <= 1'b0;
        end
        else if (div_end)
        begin
            div_cnt <= '0;
            bclk    <= ~bclk;
        end
        else
        begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // ---------------------------------------------------------------------------
    // Slot counter and serializer, all moving on falling bclk

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            bit_cnt  <= '0;
            shreg    <= '0;
            sample_q <= '0;
        end
        else if (bclk_fall)
        begin
            bit_cnt <= bit_next;

            if (slot_start)
                shreg <= slot_word;
            else
                shreg <= shreg << 1;

            if (slot_start && !bit_next[5])
                sample_q <= data_in;    // Held for the right slot
        end
    end

    assign lrclk = bit_cnt[5];          // Low for the left slot
    assign sdata = shreg[31];

    a_lrclk_on_fall : assert property (@(posedge clk) disable iff (!rst_n)
        $changed(lrclk) |-> $fell(bclk));

endmodule

`default_nettype wire

// File: hw/lab_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "board_defines.svh"

module lab_top
(
    input  logic                  clk,
    input  logic                  slow_clk,
    input  logic                  rst_n,
    input  board_io_pkg::key_t    key,
    input  board_io_pkg::sw_t     sw,
    output board_io_pkg::led_t    led,
    input  display_pkg::x_t       x,
    input  display_pkg::y_t       y,
    output display_pkg::red_t     red,
    output display_pkg::green_t   green,
    output display_pkg::blue_t    blue,
    output board_io_pkg::sample_t sound
);

    import board_io_pkg::*;
    import display_pkg::*;

    localparam int tone_w = $clog2(`TONE_HALF);
    localparam logic [tone_w - 1:0] tone_last = tone_w'(`TONE_HALF - 1);
    localparam sample_t ampl = sample_t'(`TONE_AMPL);

    logic                slow_q;
    logic                slow_rise;
    led_t                led_cnt;
    logic [tone_w - 1:0] tone_cnt;
    logic                tone_phase;

    // ---------------------------------------------------------------------------
    // Colour pattern

    assign red   = x[9:5];
    assign green = y[8:3];
    assign blue  = key[4] ? blue_t'(0) : blue_t'(sw);  // key 4 blanks blue

    // ---------------------------------------------------------------------------
    // LED tick counter

    // slow_clk comes from a flop on clk, so one stage is enough
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            slow_q <= 1'b0;
        else
            slow_q <= slow_clk;
    end

    assign slow_rise = slow_clk & ~slow_q;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            led_cnt <= '0;
        else if (slow_rise && !key[0])      // key 0 freezes the count
            led_cnt <= led_cnt + 1'b1;
    end

    assign led = led_cnt;

    // ---------------------------------------------------------------------------
    // Square wave tone

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            tone_cnt   <= '0;
            tone_phase <= 1'b0;
        end
        else if (tone_cnt == tone_last)
        begin
            tone_cnt   <= '0;
            tone_phase <= ~tone_phase;
        end
        else
        begin
            tone_cnt <= tone_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            sound <= '0;
        else if (key[1])
            sound <= tone_phase ? ampl : -ampl;
        else
            sound <= '0;                    // Silence
    end

endmodule

`default_nettype wire

// File: hw/board_specific_top.sv
`timescale 1ns/100ps
`default_nettype none

module board_specific_top
(
    input  logic                clk,
    input  logic                rst_n,

    input  board_io_pkg::key_t  key_pins,     // Active low
    input  board_io_pkg::sw_t   sw_pins,      // Active low
    output board_io_pkg::led_t  led_pins,     // Active low

    output logic                lcd_de,
    output logic                lcd_hs,
    output logic                lcd_vs,
    output logic                lcd_clk,
    output logic                lcd_bl,
    output display_pkg::red_t   lcd_r,
    output display_pkg::green_t lcd_g,
    output display_pkg::blue_t  lcd_b,

    output logic                pa_en,
    output logic                hp_din,
    output logic                hp_ws,
    output logic                hp_bck
);

    import board_io_pkg::*;
    import display_pkg::*;

    key_t    key;
    sw_t     sw;
    led_t    led;
    x_t      x;
    y_t      y;
    sample_t sound;
    logic    slow_clk;

    // ---------------------------------------------------------------------------
    // Pin polarity and enables

    assign key      = ~key_pins;
    assign sw       = ~sw_pins;
    assign led_pins = ~led;

    assign lcd_clk  = clk;              // Pixel clock is the board clock
    assign lcd_bl   = rst_n;
    assign pa_en    = rst_n;            // Headphone amplifier on

    // ---------------------------------------------------------------------------

    slow_clk_gen i_slow_clk_gen
    (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .slow_clk ( slow_clk )
    );

    lcd_timing i_lcd_timing
    (
        .clk    ( clk    ),
        .rst_n  ( rst_n  ),
        .lcd_de ( lcd_de ),
        .lcd_hs ( lcd_hs ),
        .lcd_vs ( lcd_vs ),
        .x      ( x      ),
        .y      ( y      )
    );

    lab_top i_lab_top
    (
        .clk      ( clk      ),
        .slow_clk ( slow_clk ),
        .rst_n    ( rst_n    ),
        .key      ( key      ),
        .sw       ( sw       ),
        .led      ( led      ),
        .x        ( x        ),
        .y        ( y        ),
        .red      ( lcd_r    ),
        .green    ( lcd_g    ),
        .blue     ( lcd_b    ),
        .sound    ( sound    )
    );

    // Onboard PT8211 wants LSB justified data
    i2s_audio_out
    #(
        .align_right         ( 1'b1 ),
        .offset_by_one_cycle ( 1'b0 )
    )
    i_audio_out
    (
        .clk     ( clk    ),
        .rst_n   ( rst_n  ),
        .data_in ( sound  ),
        .bclk    ( hp_bck ),
        .lrclk   ( hp_ws  ),
        .sdata   ( hp_din )
    );

endmodule

`default_nettype wire

// File: dv/tb_board_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "board_defines.svh"

module tb_board_top;

    import board_io_pkg::*;
    import display_pkg::*;

    localparam int h_total      = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK;
    localparam int v_total      = `V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK;
    localparam int frame_len    = h_total * v_total;
    localparam int audio_settle = 1100;     // Key to decoded sample latency, with margin
    localparam logic [15:0] ampl_pos = `TONE_AMPL;
    localparam logic [15:0] ampl_neg = 16'h0 - `TONE_AMPL;

    logic   clk;
    logic   rst_n;
    key_t   key_pins;
    sw_t    sw_pins;
    led_t   led_pins;
    logic   lcd_de;
    logic   lcd_hs;
    logic   lcd_vs;
    logic   lcd_clk;
    logic   lcd_bl;
    red_t   lcd_r;
    green_t lcd_g;
    blue_t  lcd_b;
    logic   pa_en;
    logic   hp_din;
    logic   hp_ws;
    logic   hp_bck;

    integer seed;
    key_t   key_v;                          // Active high view of the buttons
    sw_t    sw_v;

    // LCD tracking
    int   rst_cycles = 0;
    int   run_cycles = 0;
    bit   vs_seen    = 1'b0;
    bit   aligned    = 1'b0;
    bit   frame_done = 1'b0;
    bit   de_prev    = 1'b0;
    int   th         = 0;
    int   tv         = 0;
    int   checked    = 0;
    int   blank_cnt  = 0;

    // Slow clock and LED model
    int   sc_cnt       = 0;
    bit   sc_val       = 1'b0;
    bit   rise_pending = 1'b0;
    led_t led_exp      = '0;
    int   led_inc      = 0;
    int   led_frozen   = 0;

    // I2S decoder
    bit          bck_prev    = 1'b0;
    bit          ws_cur      = 1'b0;
    bit          slot_synced = 1'b0;
    int          slot_bits   = 0;
    logic [31:0] slot_word   = '0;
    logic [15:0] left_smp    = '0;
    bit          left_valid  = 1'b0;
    bit          key1_last   = 1'b0;
    int          key1_stable = 0;
    int          silent_cnt  = 0;
    int          pos_cnt     = 0;
    int          neg_cnt     = 0;

    initial clk = 1'b0;
    always #4 clk = ~clk;

    board_specific_top dut_i
    (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .key_pins ( key_pins ),
        .sw_pins  ( sw_pins  ),
        .led_pins ( led_pins ),
        .lcd_de   ( lcd_de   ),
        .lcd_hs   ( lcd_hs   ),
        .lcd_vs   ( lcd_vs   ),
        .lcd_clk  ( lcd_clk  ),
        .lcd_bl   ( lcd_bl   ),
        .lcd_r    ( lcd_r    ),
        .lcd_g    ( lcd_g    ),
        .lcd_b    ( lcd_b    ),
        .pa_en    ( pa_en    ),
        .hp_din   ( hp_din   ),
        .hp_ws    ( hp_ws    ),
        .hp_bck   ( hp_bck   )
    );

    // ------------------------------------------------------------------------
    // Error reporting

    task automatic stop_run();
        $display("SOME TESTS FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("FAILED %s at %0t ns: got 0x%0h, expected 0x%0h", name, $time, got, exp);
        stop_run();
    endtask

    task automatic report_problem(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        stop_run();
    endtask

    task automatic apply_inputs();
        key_pins = ~key_v;                  // Buttons and switches are active low
        sw_pins  = ~sw_v;
    endtask

    // ------------------------------------------------------------------------
    // Reference functions

    // Returns {de, hs, vs} for the position shown on the panel pins
    function automatic logic [2:0] sync_ref(int h, int v);
        logic de;
        logic hs;
        logic vs;
        de = (h < `H_ACTIVE) && (v < `V_ACTIVE);
        hs = !((h >= `H_ACTIVE + `H_FRONT) && (h < `H_ACTIVE + `H_FRONT + `H_SYNC));
        vs = !((v >= `V_ACTIVE + `V_FRONT) && (v < `V_ACTIVE + `V_FRONT + `V_SYNC));
        return {de, hs, vs};
    endfunction

    // RGB565 word, coordinates read as zero outside the active area
    function automatic logic [15:0] colour_ref(int h, int v, key_t key, sw_t sw);
        logic [9:0] px;
        logic [8:0] py;
        px = '0;
        py = '0;
        if ((h < `H_ACTIVE) && (v < `V_ACTIVE))
        begin
            px = 10'(h);
            py = 9'(v);
        end
        return {px[9:5], py[8:3], (key[4] ? 5'd0 : sw)};
    endfunction

    function automatic bit sample_legal(logic [15:0] smp, bit tone_on);
        if (tone_on)
            return (smp == ampl_pos) || (smp == ampl_neg);
        return smp == 16'h0;
    endfunction

    // One complete 32 bit slot from the decoder
    task automatic check_slot(input bit right, input logic [31:0] word, input int bits,
                              input bit tone_on, input bit settled);
        logic [15:0] smp;
        smp = word[15:0];
        assert (bits == 32) else report_problem("an I2S slot did not last 32 bit clocks");
        assert (word[31:16] == 16'h0) else
            report_mismatch("hp_din padding bits", word[31:16], 16'h0);
        if (settled)
        begin
            assert (sample_legal(smp, tone_on)) else
            begin
                if (tone_on)
                    $display("FAILED hp_din sample at %0t ns: got 0x%h, expected 0x%h or 0x%h",
                             $time, smp, ampl_pos, ampl_neg);
                else
                    $display("FAILED hp_din sample at %0t ns: got 0x%h, expected 0x0000",
                             $time, smp);
                stop_run();
            end
            if (right && left_valid)    // Right slot repeats the left sample
                assert (smp == left_smp) else report_mismatch("hp_din right sample", smp, left_smp);
            if (!tone_on)
                silent_cnt++;
            else if (smp == ampl_pos)
                pos_cnt++;
            else
                neg_cnt++;
        end
        left_valid = !right && settled;
        if (!right)
            left_smp = smp;
    endtask

    // ------------------------------------------------------------------------
    // Compare process, samples the pins just before each rising edge

    always @(posedge clk)
    begin : compare
        logic [2:0]  sync_exp;
        logic [15:0] colour_exp;
        key_t        key_now;
        sw_t         sw_now;

        key_now = ~key_pins;
        sw_now  = ~sw_pins;

        if (!rst_n)
        begin
            if (rst_cycles > 0)
            begin
                assert ({lcd_de, lcd_hs, lcd_vs} == 3'b011) else
                    report_mismatch("{lcd_de,lcd_hs,lcd_vs} in reset",
                                    {lcd_de, lcd_hs, lcd_vs}, 3'b011);
                assert (led_pins == 6'h3f) else report_mismatch("led_pins in reset", led_pins, 6'h3f);
                assert (!lcd_bl && !pa_en) else report_problem("enables are high during reset");
            end
            rst_cycles++;
        end
        else
        begin
            if (run_cycles == 0)
                assert ({lcd_de, lcd_hs, lcd_vs} == 3'b011) else
                    report_mismatch("{lcd_de,lcd_hs,lcd_vs} after reset",
                                    {lcd_de, lcd_hs, lcd_vs}, 3'b011);
            else
                assert (lcd_bl && pa_en) else report_problem("enables are low after reset");
            run_cycles++;

            // Own raster position, locked to the first frame start after a vsync
            if (aligned)
            begin
                th++;
                if (th == h_total)
                begin
                    th = 0;
                    tv = (tv == v_total - 1) ? 0 : tv + 1;
                end
            end
            else
            begin
                if (!lcd_vs)
                    vs_seen = 1'b1;
                if (vs_seen && lcd_de && !de_prev)
                begin
                    aligned = 1'b1;
                    th      = 0;
                    tv      = 0;
                end
            end
            de_prev = lcd_de;

            if (aligned)
            begin
                sync_exp   = sync_ref(th, tv);
                colour_exp = colour_ref(th, tv, key_now, sw_now);
                assert (lcd_de == sync_exp[2]) else report_mismatch("lcd_de", lcd_de, sync_exp[2]);
                assert (lcd_hs == sync_exp[1]) else report_mismatch("lcd_hs", lcd_hs, sync_exp[1]);
                assert (lcd_vs == sync_exp[0]) else report_mismatch("lcd_vs", lcd_vs, sync_exp[0]);
                assert (lcd_r == colour_exp[15:11]) else
                    report_mismatch("lcd_r", lcd_r, colour_exp[15:11]);
                assert (lcd_g == colour_exp[10:5]) else
                    report_mismatch("lcd_g", lcd_g, colour_exp[10:5]);
                assert (lcd_b == colour_exp[4:0]) else
                    report_mismatch("lcd_b", lcd_b, colour_exp[4:0]);
                if (lcd_de && key_now[4])
                    blank_cnt++;
                checked++;
                if (checked == frame_len)
                    frame_done = 1'b1;
            end

            // LED count, one step in the cycle after each slow clock rise
            assert (led_pins == ~led_exp) else
                report_mismatch("led_pins", led_pins, led_t'(~led_exp));
            if (rise_pending)
            begin
                if (!key_now[0])
                begin
                    led_exp++;
                    led_inc++;
                end
                else
                    led_frozen++;
                rise_pending = 1'b0;
            end
            if (sc_cnt == `SLOW_CLK_HALF - 1)
            begin
                sc_cnt = 0;
                sc_val = ~sc_val;
                if (sc_val)
                    rise_pending = 1'b1;
            end
            else
                sc_cnt++;

            // I2S decoder
            if (key_now[1] != key1_last)
                key1_stable = 0;
            else if (key1_stable < audio_settle)
                key1_stable++;
            key1_last = key_now[1];

            if (hp_bck && !bck_prev)
            begin
                if (hp_ws != ws_cur)
                begin
                    if (slot_synced)
                        check_slot(ws_cur, slot_word, slot_bits, key_now[1],
                                   key1_stable >= audio_settle);
                    slot_synced = 1'b1;
                    ws_cur      = hp_ws;
                    slot_bits   = 0;
                    slot_word   = '0;
                end
                slot_word = {slot_word[30:0], hp_din};
                slot_bits++;
            end
            bck_prev = hp_bck;
        end
    end

    // Pixel clock pin, looked at half way through each clk phase
    always @(clk)
    begin : pixel_clock_check
        #2;
        assert (lcd_clk == clk) else report_mismatch("lcd_clk", lcd_clk, clk);
    end

    // ------------------------------------------------------------------------
    // Stimulus

    initial
    begin : stimulus
        int          n;
        logic [31:0] r;

        seed  = 32'he48e_a658;
        rst_n = 1'b0;
        key_v = '0;
        sw_v  = 5'($random(seed));
        apply_inputs();

        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        // Random switches, key 4 and key 0 while a whole frame is checked
        n = 0;
        while (!frame_done && n < 3 * frame_len)
        begin
            @(negedge clk);
            r = $random(seed);
            if (r[7:0] == 8'h00)
                sw_v = r[20:16];
            if (r[15:8] == 8'h00)
                key_v[4] = ~key_v[4];
            if (r[31:24] == 8'h00)
                key_v[0] = ~key_v[0];
            apply_inputs();
            n++;
        end
        if (!frame_done)
            report_problem("timeout waiting for a full LCD frame to be checked");

        assert (blank_cnt > 0) else report_problem("key 4 was never held on an active pixel");
        assert (led_inc > 0 && led_frozen > 0) else
            report_problem("LED counter was not seen both counting and frozen");
        assert (silent_cnt > 0) else report_problem("no silent I2S sample was decoded");

        // Tone on key 1
        key_v = 5'b00010;
        apply_inputs();
        repeat (audio_settle + 4 * `TONE_HALF) @(negedge clk);
        assert (pos_cnt > 0 && neg_cnt > 0) else
            report_problem("the tone did not show both polarities");

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+hw
hw/board_io_pkg.sv
hw/display_pkg.sv
hw/slow_clk_gen.sv
hw/lcd_timing.sv
hw/i2s_audio_out.sv
hw/lab_top.sv
hw/board_specific_top.sv
dv/tb_board_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the board testbench with Verilator, run it and check the log

set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log
pass_text="ALL TESTS PASSED"

if ! verilator --binary --timing --assert -Wno-fatal \
        -f src.f --top-module tb_board_top \
        -Mdir "$build_dir" -o tb_board_top; then
    echo "Verilator build failed"
    exit 1
fi

"./$build_dir/tb_board_top" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"

if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "$pass_text" "$log_file"; then
    exit 0
fi

echo "Pass message not found in $log_file"
exit 1
